/* rvPkg.sv */
package rvPkg;

    localparam int xlen = 64;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opImm    = 7'b0010011,
        opImm32  = 7'b0011011,
        opReg    = 7'b0110011,
        opReg32  = 7'b0111011
    } opcodeT;

    // load / store sizes
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3Dword = 3'b011;
    localparam logic [2:0] f3Lbu   = 3'b100;
    localparam logic [2:0] f3Lhu   = 3'b101;

    // branch conditions
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000; // sub, sra
    localparam logic [6:0] f7MulDiv = 7'b0000001; // M extension

    // sign-extend a 32-bit result to full width
    function automatic logic [xlen-1:0] sext32(input logic [31:0] v);
        return {{(xlen-32){v[31]}}, v};
    endfunction

endpackage

/* immGen.sv */
`timescale 1ns/100ps

module immGen import rvPkg::*; (
    input  logic [31:0]     inst,
    output logic [xlen-1:0] immI,
    output logic [xlen-1:0] immS,
    output logic [xlen-1:0] immB,
    output logic [xlen-1:0] immU,
    output logic [xlen-1:0] immJ,
    output logic [2:0]      funct3,
    output logic [6:0]      funct7
);

    logic signBit;

    assign signBit = inst[31]; // every format takes its sign from bit 31

    assign immI = {{(xlen-12){signBit}}, inst[31:20]};

    assign immS = {{(xlen-12){signBit}}, inst[31:25], inst[11:7]};

    assign immB = {{(xlen-13){signBit}}, inst[31], inst[7], inst[30:25],
                   inst[11:8], 1'b0}; // low bit always zero

    assign immU = {{(xlen-32){signBit}}, inst[31:12], 12'b0};

    assign immJ = {{(xlen-21){signBit}}, inst[31], inst[19:12], inst[20],
                   inst[30:21], 1'b0};

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25]; // also upper bits of shamt for imm shifts

endmodule

/* execUnit.sv */
`timescale 1ns/100ps

module execUnit import rvPkg::*; (
    input  logic [xlen-1:0] pc,
    input  logic [31:0]     inst,
    input  logic [xlen-1:0] rs1Data,
    input  logic [xlen-1:0] rs2Data,
    input  logic [xlen-1:0] immI,
    input  logic [xlen-1:0] immS,
    input  logic [xlen-1:0] immB,
    input  logic [xlen-1:0] immU,
    input  logic [xlen-1:0] immJ,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [xlen-1:0] memRdata,
    output logic            wen,
    output logic [4:0]      rdAddr,
    output logic [xlen-1:0] wdata,
    output logic [xlen-1:0] newPc,
    output logic [xlen-1:0] memAddr,
    output logic [xlen-1:0] memWdata,
    output logic [7:0]      memMask
);

    opcodeT          opcode;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] loadLane;
    logic [7:0]      sizeMask;
    logic [31:0]     a32;
    logic [31:0]     b32;
    logic [31:0]     addiW, sliW, sriW, sraiW;
    logic [31:0]     addW, subW, sllW, srlW, sraW, mulW;
    logic [31:0]     divW, divuW, remW, remuW;
    logic signed [31:0] quotS;
    logic signed [31:0] remS;
    logic            divOvf;
    logic            taken;

    assign opcode  = opcodeT'(inst[6:0]);
    assign rdAddr  = inst[11:7];
    assign pcPlus4 = pc + xlen'(4);

    // immS for stores and immI for loads
    assign memAddr  = (opcode == opStore) ? rs1Data + immS : rs1Data + immI;
    assign loadLane = memRdata >> {memAddr[2:0], 3'b000};
    assign memWdata = rs2Data << {memAddr[2:0], 3'b000};

    // 32-bit ops sign-extended at writeback
    assign a32    = rs1Data[31:0];
    assign b32    = rs2Data[31:0];
    assign addiW  = a32 + immI[31:0];
    assign sliW   = a32 << immI[4:0];
    assign sriW   = a32 >> immI[4:0];
    assign sraiW  = $signed(a32) >>> immI[4:0];
    assign addW   = a32 + b32;
    assign subW   = a32 - b32;
    assign sllW   = a32 << b32[4:0];
    assign srlW   = a32 >> b32[4:0];
    assign sraW   = $signed(a32) >>> b32[4:0];
    assign mulW   = a32 * b32; // low half only
    assign divOvf = (a32 == 32'h8000_0000) && (b32 == 32'hffff_ffff);
    assign quotS  = $signed(a32) / $signed(b32);
    assign remS   = $signed(a32) % $signed(b32);
    assign divW   = (b32 == '0) ? 32'hffff_ffff : divOvf ? a32 : quotS;
    assign divuW  = (b32 == '0) ? 32'hffff_ffff : a32 / b32;
    assign remW   = (b32 == '0) ? a32 : divOvf ? 32'h0 : remS;
    assign remuW  = (b32 == '0) ? a32 : a32 % b32;

    always_comb begin
        case (funct3)
            f3Beq:   taken = (rs1Data == rs2Data);
            f3Bne:   taken = (rs1Data != rs2Data);
            f3Blt:   taken = ($signed(rs1Data) < $signed(rs2Data));
            f3Bge:   taken = ($signed(rs1Data) >= $signed(rs2Data));
            f3Bltu:  taken = (rs1Data < rs2Data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            f3Byte:  sizeMask = 8'h01;
            f3Half:  sizeMask = 8'h03;
            f3Word:  sizeMask = 8'h0f;
            f3Dword: sizeMask = 8'hff;
            default: sizeMask = 8'h00;
        endcase
        memMask = (opcode == opStore) ? sizeMask << memAddr[2:0] : 8'h00;
    end

    always_comb begin
        wen   = 1'b1;
        wdata = '0;
        newPc = pcPlus4;
        case (opcode)
            opLoad: begin
                case (funct3)
                    f3Dword: wdata = loadLane;
                    f3Word:  wdata = sext32(loadLane[31:0]);
                    f3Half:  wdata = {{(xlen-16){loadLane[15]}}, loadLane[15:0]};
                    f3Lhu:   wdata = {{(xlen-16){1'b0}}, loadLane[15:0]};
                    f3Lbu:   wdata = {{(xlen-8){1'b0}}, loadLane[7:0]};
                    default: wen = 1'b0;
                endcase
            end
            opLui:   wdata = immU;
            opAuipc: wdata = pc + immU;
            opJal: begin
                wdata = pcPlus4; // link
                newPc = pc + immJ;
            end
            opJalr: begin
                wen   = (funct3 == 3'b000);
                wdata = pcPlus4;
                if (funct3 == 3'b000) begin
                    newPc = (rs1Data + immI) & ~xlen'(1);
                end
            end
            opBranch: begin
                wen = 1'b0;
                if (taken) begin
                    newPc = pc + immB;
                end
            end
            opImm: begin
                case (funct3)
                    3'b000: wdata = rs1Data + immI;
                    3'b111: wdata = rs1Data & immI;
                    3'b100: wdata = rs1Data ^ immI;
                    3'b011: wdata = {{(xlen-1){1'b0}}, rs1Data < immI}; // sltiu
                    3'b001: wdata = rs1Data << immI[5:0];
                    3'b101: begin
                        if (funct7[6:1] == f7Alt[6:1]) begin
                            wdata = $signed(rs1Data) >>> immI[5:0]; // srai
                        end else begin
                            wdata = rs1Data >> immI[5:0];
                        end
                    end
                    default: wen = 1'b0;
                endcase
            end
            opImm32: begin
                case ({funct7, funct3})
                    {f7Base, 3'b001}: wdata = sext32(sliW);
                    {f7Base, 3'b101}: wdata = sext32(sriW);
                    {f7Alt, 3'b101}:  wdata = sext32(sraiW);
                    default: begin
                        wen   = (funct3 == 3'b000); // addiw takes any imm bits
                        wdata = sext32(addiW);
                    end
                endcase
            end
            opReg: begin
                case ({funct7, funct3})
                    {f7Base, 3'b000}:   wdata = rs1Data + rs2Data;
                    {f7Alt, 3'b000}:    wdata = rs1Data - rs2Data;
                    {f7MulDiv, 3'b000}: wdata = rs1Data * rs2Data;
                    {f7Base, 3'b111}:   wdata = rs1Data & rs2Data;
                    {f7Base, 3'b110}:   wdata = rs1Data | rs2Data;
                    {f7Base, 3'b010}:
                        wdata = {{(xlen-1){1'b0}}, $signed(rs1Data) < $signed(rs2Data)};
                    {f7Base, 3'b011}:   wdata = {{(xlen-1){1'b0}}, rs1Data < rs2Data};
                    default:            wen = 1'b0;
                endcase
            end
            opReg32: begin
                case ({funct7, funct3})
                    {f7Base, 3'b000}:   wdata = sext32(addW);
                    {f7Alt, 3'b000}:    wdata = sext32(subW);
                    {f7Base, 3'b001}:   wdata = sext32(sllW);
                    {f7Base, 3'b101}:   wdata = sext32(srlW);
                    {f7Alt, 3'b101}:    wdata = sext32(sraW);
                    {f7MulDiv, 3'b000}: wdata = sext32(mulW);
                    {f7MulDiv, 3'b100}: wdata = sext32(divW);
                    {f7MulDiv, 3'b101}: wdata = sext32(divuW);
                    {f7MulDiv, 3'b110}: wdata = sext32(remW);
                    {f7MulDiv, 3'b111}: wdata = sext32(remuW);
                    default:            wen = 1'b0;
                endcase
            end
            default: wen = 1'b0; // stores and unknown opcodes
        endcase
    end

endmodule

/* regFile.sv */
`timescale 1ns/100ps

module regFile import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [4:0]      rs1Addr,
    input  logic [4:0]      rs2Addr,
    input  logic            wen,
    input  logic [4:0]      rdAddr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rs1Data,
    output logic [xlen-1:0] rs2Data
);

    logic [xlen-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rdAddr != 5'd0) begin
            regs[rdAddr] <= wdata;
        end
    end

    // async read, x0 reads zero
    always_comb begin
        rs1Data = '0;
        rs2Data = '0;
        if (rs1Addr != 5'd0) begin
            rs1Data = regs[rs1Addr];
        end
        if (rs2Addr != 5'd0) begin
            rs2Data = regs[rs2Addr];
        end
    end

endmodule

/* dataMem.sv */
`timescale 1ns/100ps

module dataMem import rvPkg::*; #(
    parameter int memWords = 256
) (
    input  logic            clk,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    input  logic [7:0]      mask,
    output logic [xlen-1:0] rdata
);

    localparam int idxW = (memWords > 1) ? $clog2(memWords) : 1;

    logic [xlen-1:0] mem [0:memWords-1];
    logic [idxW-1:0] idx;

    assign idx = addr[3 +: idxW]; // doubleword index, byte offset dropped

    // byte-masked write
    always_ff @(posedge clk) begin
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                mem[idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    assign rdata = mem[idx]; // whole doubleword, lane picked by execUnit

endmodule

/* rvCore.sv */
`timescale 1ns/100ps

module rvCore import rvPkg::*; #(
    parameter int              memWords = 256,
    parameter logic [xlen-1:0] resetPc  = '0
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic [31:0]     inst,
    output logic [xlen-1:0] pc,
    output logic            wbEn,
    output logic [4:0]      wbAddr,
    output logic [xlen-1:0] wbData
);

    logic [xlen-1:0] immI, immS, immB, immU, immJ;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] rs1Data, rs2Data;
    logic            wen;
    logic [4:0]      rdAddr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] newPc;
    logic [xlen-1:0] memAddr, memWdata, memRdata;
    logic [7:0]      memMask;
    logic [7:0]      memWe;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= newPc;
        end
    end

    immGen uImm (
        .inst  (inst),
        .immI  (immI),
        .immS  (immS),
        .immB  (immB),
        .immU  (immU),
        .immJ  (immJ),
        .funct3(funct3),
        .funct7(funct7)
    );

    regFile uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .rs1Addr(inst[19:15]),
        .rs2Addr(inst[24:20]),
        .wen    (wen),
        .rdAddr (rdAddr),
        .wdata  (wdata),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    execUnit uExec (
        .pc      (pc),
        .inst    (inst),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .immI    (immI),
        .immS    (immS),
        .immB    (immB),
        .immU    (immU),
        .immJ    (immJ),
        .funct3  (funct3),
        .funct7  (funct7),
        .memRdata(memRdata),
        .wen     (wen),
        .rdAddr  (rdAddr),
        .wdata   (wdata),
        .newPc   (newPc),
        .memAddr (memAddr),
        .memWdata(memWdata),
        .memMask (memMask)
    );

    assign memWe = rstN ? memMask : 8'h00; // no stores while in reset

    dataMem #(.memWords(memWords)) uMem (
        .clk  (clk),
        .addr (memAddr),
        .wdata(memWdata),
        .mask (memWe),
        .rdata(memRdata)
    );

    // retire ports
    assign wbEn   = wen;
    assign wbAddr = rdAddr;
    assign wbData = wdata;

endmodule

/* coreChecker.sv */
`timescale 1ns/100ps

module coreChecker import rvPkg::*; (
    input  logic            clk,
    input  logic            checkEn,
    input  int              rowIdx,
    input  logic [xlen-1:0] expPc,
    input  logic            expWbEn,
    input  logic [4:0]      expWbAddr,
    input  logic [xlen-1:0] expWbData,
    input  logic [xlen-1:0] pc,
    input  logic            wbEn,
    input  logic [4:0]      wbAddr,
    input  logic [xlen-1:0] wbData,
    output int              errCount,
    output int              checkCount
);

    task automatic compareValue(input string name, input logic [xlen-1:0] expected,
            input logic [xlen-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("[ERROR] row %0d %s: expected %h, got %h", rowIdx, name, expected, actual);
        end
    endtask

    initial begin
        errCount   = 0;
        checkCount = 0;
    end

    // sampled mid-cycle, inst and pc only move on the rising edge
    always @(negedge clk) begin
        if (checkEn) begin
            compareValue("pc", expPc, pc);
            compareValue("wbEn", xlen'(expWbEn), xlen'(wbEn));
            if (expWbEn) begin // addr and data only matter on a write
                compareValue("wbAddr", xlen'(expWbAddr), xlen'(wbAddr));
                compareValue("wbData", expWbData, wbData);
            end
        end
    end

endmodule

/* tbRvCore.sv */
`timescale 1ns/100ps

module tbRvCore import rvPkg::*; ();

    localparam int resetCycles = 16;

    logic            clk;
    logic            rstN;
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
    logic            wbEn;
    logic [4:0]      wbAddr;
    logic [xlen-1:0] wbData;

    // program table, one row per cycle
    logic [31:0]     instQ [$];
    logic [xlen-1:0] pcQ [$];
    logic            enQ [$];
    logic [4:0]      addrQ [$];
    logic [xlen-1:0] dataQ [$];

    logic            checkEn;
    int              rowIdx;
    logic [xlen-1:0] expPc;
    logic            expWbEn;
    logic [4:0]      expWbAddr;
    logic [xlen-1:0] expWbData;
    int              errCount;
    int              checkCount;
    int              cycleCount = 0;
    int              cycleLimit = 1000;

    rvCore #(.memWords(256), .resetPc('0)) UUT (
        .clk(clk), .rstN(rstN), .inst(inst),
        .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    coreChecker uCheck (
        .clk(clk), .checkEn(checkEn), .rowIdx(rowIdx),
        .expPc(expPc), .expWbEn(expWbEn), .expWbAddr(expWbAddr), .expWbData(expWbData),
        .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .errCount(errCount), .checkCount(checkCount)
    );

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2, rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2, rs1,
            input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2, rs1,
            input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    task automatic addRow(input logic [31:0] i, input logic [xlen-1:0] p, input logic en,
            input logic [4:0] rd, input logic [xlen-1:0] d);
        instQ.push_back(i);
        pcQ.push_back(p);
        enQ.push_back(en);
        addrQ.push_back(rd);
        dataQ.push_back(d);
    endtask

    task automatic loadProgram();
        addRow(iType(12'd5, 0, 3'b000, 1, opImm), 0, 1, 1, 64'h5);
        addRow(iType(12'hffd, 0, 3'b000, 2, opImm), 4, 1, 2, 64'hffff_ffff_ffff_fffd);
        addRow(rType(f7Base, 2, 1, 3'b000, 3, opReg), 8, 1, 3, 64'h2);
        addRow(rType(f7Alt, 2, 1, 3'b000, 4, opReg), 12, 1, 4, 64'h8);
        addRow(rType(f7Base, 2, 1, 3'b111, 5, opReg), 16, 1, 5, 64'h5);
        addRow(rType(f7Base, 2, 1, 3'b110, 6, opReg), 20, 1, 6, 64'hffff_ffff_ffff_fffd);
        addRow(rType(f7Base, 1, 2, 3'b010, 7, opReg), 24, 1, 7, 64'h1); // slt -3 < 5
        addRow(rType(f7Base, 1, 2, 3'b011, 8, opReg), 28, 1, 8, 64'h0);
        addRow(iType(12'd6, 1, 3'b011, 9, opImm), 32, 1, 9, 64'h1);
        addRow(iType(12'h0ff, 1, 3'b100, 10, opImm), 36, 1, 10, 64'hfa);
        addRow(iType(12'd60, 1, 3'b001, 11, opImm), 40, 1, 11, 64'h5000_0000_0000_0000);
        addRow(iType(12'd60, 2, 3'b101, 12, opImm), 44, 1, 12, 64'hf);
        addRow(iType(12'h401, 2, 3'b101, 13, opImm), 48, 1, 13, 64'hffff_ffff_ffff_fffe);
        addRow({20'h80000, 5'd14, opLui}, 52, 1, 14, 64'hffff_ffff_8000_0000);
        addRow({20'h00001, 5'd15, opAuipc}, 56, 1, 15, 64'h1038);
        addRow(rType(f7MulDiv, 2, 1, 3'b000, 16, opReg), 60, 1, 16, 64'hffff_ffff_ffff_fff1);
        addRow(rType(f7Base, 1, 14, 3'b000, 17, opReg32), 64, 1, 17, 64'hffff_ffff_8000_0005);
        addRow(rType(f7Alt, 1, 0, 3'b000, 18, opReg32), 68, 1, 18, 64'hffff_ffff_ffff_fffb);
        addRow(rType(f7Base, 1, 2, 3'b001, 19, opReg32), 72, 1, 19, 64'hffff_ffff_ffff_ffa0);
        addRow(rType(f7Base, 1, 14, 3'b101, 20, opReg32), 76, 1, 20, 64'h0400_0000);
        addRow(rType(f7Alt, 1, 14, 3'b101, 21, opReg32), 80, 1, 21, 64'hffff_ffff_fc00_0000);
        addRow(rType(f7MulDiv, 4, 2, 3'b000, 22, opReg32), 84, 1, 22, 64'hffff_ffff_ffff_ffe8);
        addRow(iType(12'd100, 0, 3'b000, 24, opImm), 88, 1, 24, 64'h64);
        addRow(iType(12'hff9, 0, 3'b000, 25, opImm), 92, 1, 25, 64'hffff_ffff_ffff_fff9);
        addRow(rType(f7MulDiv, 25, 24, 3'b100, 26, opReg32), 96, 1, 26, 64'hffff_ffff_ffff_fff2);
        addRow(rType(f7MulDiv, 25, 24, 3'b110, 27, opReg32), 100, 1, 27, 64'h2);
        addRow(rType(f7MulDiv, 24, 25, 3'b101, 28, opReg32), 104, 1, 28, 64'h028f_5c28);
        addRow(rType(f7MulDiv, 24, 25, 3'b111, 29, opReg32), 108, 1, 29, 64'h59);
        addRow(rType(f7MulDiv, 0, 25, 3'b100, 30, opReg32), 112, 1, 30, 64'hffff_ffff_ffff_ffff);
        addRow(rType(f7MulDiv, 0, 25, 3'b110, 31, opReg32), 116, 1, 31, 64'hffff_ffff_ffff_fff9);
        addRow(iType(12'd7, 0, 3'b000, 0, opImm), 120, 1, 0, 64'h7); // write to x0 is dropped
        addRow(rType(f7Base, 1, 0, 3'b110, 3, opReg), 124, 1, 3, 64'h5);
        // stores into the doubleword at 0x100, then read back
        addRow(sType(12'h100, 11, 0, f3Dword), 128, 0, 0, 0);
        addRow(sType(12'h101, 10, 0, f3Byte), 132, 0, 0, 0);
        addRow(sType(12'h102, 25, 0, f3Half), 136, 0, 0, 0);
        addRow(iType(12'h100, 0, f3Dword, 8, opLoad), 140, 1, 8, 64'h5000_0000_fff9_fa00);
        addRow(iType(12'h100, 0, f3Word, 9, opLoad), 144, 1, 9, 64'hffff_ffff_fff9_fa00);
        addRow(iType(12'h104, 0, f3Word, 12, opLoad), 148, 1, 12, 64'h5000_0000);
        addRow(iType(12'h102, 0, f3Half, 13, opLoad), 152, 1, 13, 64'hffff_ffff_ffff_fff9);
        addRow(iType(12'h102, 0, f3Lhu, 14, opLoad), 156, 1, 14, 64'hfff9);
        addRow(iType(12'h101, 0, f3Lbu, 15, opLoad), 160, 1, 15, 64'hfa);
        addRow(32'h0000_0000, 164, 0, 0, 0); // unknown opcode
        // branches, taken rows skip ahead
        addRow(bType(13'd8, 3, 1, f3Beq), 168, 0, 0, 0);
        addRow(bType(13'd8, 2, 1, f3Beq), 176, 0, 0, 0);
        addRow(bType(13'd12, 2, 1, f3Bne), 180, 0, 0, 0);
        addRow(bType(13'd8, 3, 1, f3Bne), 192, 0, 0, 0);
        addRow(bType(13'd8, 1, 2, f3Blt), 196, 0, 0, 0);
        addRow(bType(13'd8, 2, 1, f3Blt), 204, 0, 0, 0);
        addRow(bType(13'd8, 2, 1, f3Bge), 208, 0, 0, 0);
        addRow(bType(13'd8, 1, 2, f3Bge), 216, 0, 0, 0);
        addRow(bType(13'd8, 2, 1, f3Bltu), 220, 0, 0, 0);
        addRow(bType(13'd8, 1, 2, f3Bltu), 228, 0, 0, 0);
        addRow({1'b0, 10'd8, 1'b0, 8'h00, 5'd1, opJal}, 232, 1, 1, 64'hec); // jal +16
        addRow(iType(12'h041, 1, 3'b000, 5, opJalr), 248, 1, 5, 64'hfc); // target 0x12c
        addRow(rType(f7Base, 0, 5, 3'b000, 6, opReg), 300, 1, 6, 64'hfc);
    endtask

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: program did not finish within %0d cycles", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        rstN      = 1'b0;
        inst      = 32'h0000_0013; // nop during reset
        checkEn   = 1'b0;
        rowIdx    = 0;
        expPc     = '0;
        expWbEn   = 1'b0;
        expWbAddr = '0;
        expWbData = '0;
        loadProgram();
        cycleLimit = instQ.size() + resetCycles + 20;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < instQ.size(); i++) begin
            inst      <= instQ[i];
            rowIdx    <= i;
            expPc     <= pcQ[i];
            expWbEn   <= enQ[i];
            expWbAddr <= addrQ[i];
            expWbData <= dataQ[i];
            checkEn   <= 1'b1;
            @(posedge clk);
        end
        checkEn <= 1'b0;
        @(negedge clk);
        $display("rows %0d, checks %0d, errors %0d", instQ.size(), checkCount, errCount);
        if (errCount == 0 && checkCount > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* files.f */
rvPkg.sv
immGen.sv
execUnit.sv
regFile.sv
dataMem.sv
rvCore.sv
coreChecker.sv
tbRvCore.sv
